/* source/cmd_axi_pkg.sv */
package cmd_axi_pkg;

  // Burst and buffer sizing
  localparam int MAX_BEATS  = 16;
  localparam int FIFO_DEPTH = 16;

  // AXI response and burst codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  localparam logic [1:0] BURST_INCR  = 2'b01;

  typedef logic [31:0] addr_t;    // Byte address
  typedef logic [31:0] data_t;    // AXI data word
  typedef logic [7:0]  byte_t;    // Host data byte
  typedef logic [3:0]  axi_id_t;
  typedef logic [7:0]  axi_len_t; // AXI beats minus one
  typedef logic [$clog2(MAX_BEATS):0] beats_t;  // 1 to MAX_BEATS words
  typedef logic [1:0]  resp_t;

  // Host command, dir set means read
  typedef struct packed {
    logic    dir;
    axi_id_t id;
    beats_t  beats;
    addr_t   addr;
  } host_cmd_t;

  typedef struct packed {
    byte_t data;
    logic  last;
  } host_byte_t;

  // One 32-bit beat as buffered in either FIFO
  typedef struct packed {
    data_t data;
    logic  last;
    logic  err;
  } word_beat_t;

  typedef struct packed {
    byte_t data;
    logic  last;
    logic  err;
  } rd_byte_t;

  typedef struct packed {
    axi_id_t id;
    logic    okay;
  } wr_resp_t;

endpackage

/* source/byte_word_packer.sv */
module byte_word_packer (
  input  logic                    aclk,
  input  logic                    aresetn,
  input  logic                    byte_stb_i,
  input  cmd_axi_pkg::host_byte_t byte_i,
  output logic                    word_stb_o,
  output cmd_axi_pkg::word_beat_t word_o
);
  import cmd_axi_pkg::*;

  logic [1:0] lane_q;  // Next byte lane to fill
  data_t      shift_q;
  logic       last_q;

  // Lane counter and word strobe
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      lane_q     <= 2'd0;
      word_stb_o <= 1'b0;
    end else begin
      word_stb_o <= byte_stb_i && (lane_q == 2'd3);
      if (byte_stb_i) begin
        lane_q <= byte_i.last ? 2'd0 : lane_q + 2'd1;  // Realign on burst end
      end
    end
  end

  // Bytes enter at the top and move down, so the first byte lands in bits 7:0
  always_ff @(posedge aclk) begin
    if (byte_stb_i) begin
      shift_q <= {byte_i.data, shift_q[$bits(data_t)-1:$bits(byte_t)]};
      last_q  <= byte_i.last;
    end
  end

  // Write data carries no error
  assign word_o.data = shift_q;
  assign word_o.last = last_q;
  assign word_o.err  = 1'b0;

endmodule

/* source/word_fifo.sv */
module word_fifo #(
  parameter int DEPTH = 16
) (
  input  logic                    aclk,
  input  logic                    aresetn,
  input  logic                    push_i,
  input  cmd_axi_pkg::word_beat_t push_data_i,
  input  logic                    pop_i,
  output cmd_axi_pkg::word_beat_t pop_data_o,
  output logic                    empty_o,
  output logic                    full_o
);
  import cmd_axi_pkg::*;

  word_beat_t                 mem_q [DEPTH];
  logic [$clog2(DEPTH)-1:0]   wr_ptr_q;
  logic [$clog2(DEPTH)-1:0]   rd_ptr_q;
  logic [$clog2(DEPTH):0]     count_q;
  logic                       do_push;
  logic                       do_pop;

  assign do_push = push_i && !full_o;   // Push on full is dropped
  assign do_pop  = pop_i && !empty_o;

  assign empty_o = (count_q == 0);
  assign full_o  = (count_q == DEPTH);

  // Head word is always presented
  assign pop_data_o = mem_q[rd_ptr_q];

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Both or neither
      endcase
    end
  end

  // Storage
  always_ff @(posedge aclk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

/* source/axi_write_engine.sv */
module axi_write_engine (
  input  logic                    aclk,
  input  logic                    aresetn,
  input  logic                    cmd_stb_i,
  input  cmd_axi_pkg::host_cmd_t  cmd_i,
  input  cmd_axi_pkg::word_beat_t fifo_data_i,
  input  logic                    fifo_empty_i,
  output logic                    fifo_pop_o,
  output logic                    awvalid_o,
  input  logic                    awready_i,
  output cmd_axi_pkg::addr_t      awaddr_o,
  output cmd_axi_pkg::axi_id_t    awid_o,
  output cmd_axi_pkg::axi_len_t   awlen_o,
  output logic [1:0]              awburst_o,
  output logic                    wvalid_o,
  input  logic                    wready_i,
  output cmd_axi_pkg::data_t      wdata_o,
  output logic [3:0]              wstrb_o,
  output logic                    wlast_o,
  input  logic                    bvalid_i,
  output logic                    bready_o,
  input  cmd_axi_pkg::resp_t      bresp_i,
  input  cmd_axi_pkg::axi_id_t    bid_i,
  output logic                    resp_stb_o,
  output cmd_axi_pkg::wr_resp_t   resp_o,
  output logic                    busy_o
);
  import cmd_axi_pkg::*;

  typedef enum logic [1:0] {IDLE, ADDR, DATA, RESP} state_t;

  state_t   state_q;
  addr_t    addr_q;
  axi_id_t  id_q;
  axi_len_t len_q;
  logic     b_hs;

  assign b_hs = bvalid_i && bready_o;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      state_q    <= IDLE;
      resp_stb_o <= 1'b0;
    end else begin
      resp_stb_o <= b_hs;
      case (state_q)
        IDLE: if (cmd_stb_i && !cmd_i.dir) state_q <= ADDR;
        ADDR: if (awready_i) state_q <= DATA;
        DATA: if (fifo_pop_o && fifo_data_i.last) state_q <= RESP;
        RESP: if (b_hs) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // Command fields and response payload
  always_ff @(posedge aclk) begin
    if (state_q == IDLE && cmd_stb_i) begin
      addr_q <= cmd_i.addr;
      id_q   <= cmd_i.id;
      len_q  <= axi_len_t'(cmd_i.beats) - 8'd1;
    end
    if (b_hs) begin
      resp_o.id   <= bid_i;
      resp_o.okay <= (bresp_i == RESP_OKAY);
    end
  end

  assign awvalid_o = (state_q == ADDR);
  assign awaddr_o  = addr_q;
  assign awid_o    = id_q;
  assign awlen_o   = len_q;
  assign awburst_o = BURST_INCR;

  // W streams straight from the FIFO head, a wready stall just holds it
  assign wvalid_o   = (state_q == DATA) && !fifo_empty_i;
  assign wdata_o    = fifo_data_i.data;
  assign wstrb_o    = '1;  // Full words only
  assign wlast_o    = wvalid_o && fifo_data_i.last;
  assign fifo_pop_o = wvalid_o && wready_i;

  assign bready_o = (state_q == RESP);
  assign busy_o   = (state_q != IDLE);

endmodule

/* source/axi_read_engine.sv */
module axi_read_engine (
  input  logic                    aclk,
  input  logic                    aresetn,
  input  logic                    cmd_stb_i,
  input  cmd_axi_pkg::host_cmd_t  cmd_i,
  input  logic                    fifo_full_i,
  output logic                    fifo_push_o,
  output cmd_axi_pkg::word_beat_t fifo_data_o,
  output logic                    arvalid_o,
  input  logic                    arready_i,
  output cmd_axi_pkg::addr_t      araddr_o,
  output cmd_axi_pkg::axi_id_t    arid_o,
  output cmd_axi_pkg::axi_len_t   arlen_o,
  output logic [1:0]              arburst_o,
  input  logic                    rvalid_i,
  output logic                    rready_o,
  input  cmd_axi_pkg::data_t      rdata_i,
  input  cmd_axi_pkg::resp_t      rresp_i,
  input  logic                    rlast_i,
  input  logic                    drain_done_i,
  output logic                    busy_o
);
  import cmd_axi_pkg::*;

  typedef enum logic [1:0] {IDLE, ADDR, DATA, DRAIN} state_t;

  state_t   state_q;
  addr_t    addr_q;
  axi_id_t  id_q;
  axi_len_t len_q;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:  if (cmd_stb_i && cmd_i.dir) state_q <= ADDR;
        ADDR:  if (arready_i) state_q <= DATA;
        DATA:  if (fifo_push_o && rlast_i) state_q <= DRAIN;
        DRAIN: if (drain_done_i) state_q <= IDLE;  // Host has the last byte
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (state_q == IDLE && cmd_stb_i) begin
      addr_q <= cmd_i.addr;
      id_q   <= cmd_i.id;
      len_q  <= axi_len_t'(cmd_i.beats) - 8'd1;
    end
  end

  assign arvalid_o = (state_q == ADDR);
  assign araddr_o  = addr_q;
  assign arid_o    = id_q;
  assign arlen_o   = len_q;
  assign arburst_o = BURST_INCR;

  // The read FIFO back-pressures R directly
  assign rready_o    = (state_q == DATA) && !fifo_full_i;
  assign fifo_push_o = rvalid_i && rready_o;

  assign fifo_data_o.data = rdata_i;
  assign fifo_data_o.last = rlast_i;
  assign fifo_data_o.err  = (rresp_i != RESP_OKAY);

  assign busy_o = (state_q != IDLE);

endmodule

/* source/word_byte_unpacker.sv */
module word_byte_unpacker (
  input  logic                    aclk,
  input  logic                    aresetn,
  input  cmd_axi_pkg::word_beat_t fifo_data_i,
  input  logic                    fifo_empty_i,
  output logic                    fifo_pop_o,
  output logic                    byte_stb_o,
  output cmd_axi_pkg::rd_byte_t   byte_o
);
  import cmd_axi_pkg::*;

  logic [1:0] lane_q;  // Byte of the head word sent next
  logic       emit;

  assign emit       = !fifo_empty_i;
  assign fifo_pop_o = emit && (lane_q == 2'd3);  // Word done after lane 3

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      lane_q     <= 2'd0;
      byte_stb_o <= 1'b0;
    end else begin
      byte_stb_o <= emit;
      if (emit) begin
        lane_q <= lane_q + 2'd1;  // Wraps onto the next word
      end
    end
  end

  // Little-endian lane select
  always_ff @(posedge aclk) begin
    if (emit) begin
      byte_o.data <= fifo_data_i.data[8*lane_q +: 8];
      byte_o.last <= fifo_data_i.last && (lane_q == 2'd3);
      byte_o.err  <= fifo_data_i.err;
    end
  end

endmodule

/* source/cmd_to_axi.sv */
module cmd_to_axi (
  input  logic                    aclk,
  input  logic                    aresetn,
  // Host port
  input  logic                    cmd_stb_i,
  input  cmd_axi_pkg::host_cmd_t  cmd_i,
  input  logic                    wr_stb_i,
  input  cmd_axi_pkg::host_byte_t wr_byte_i,
  output logic                    rd_stb_o,
  output cmd_axi_pkg::rd_byte_t   rd_byte_o,
  output logic                    wr_resp_stb_o,
  output cmd_axi_pkg::wr_resp_t   wr_resp_o,
  output logic                    busy_o,
  // AXI4 master
  output logic                    awvalid_o,
  input  logic                    awready_i,
  output cmd_axi_pkg::addr_t      awaddr_o,
  output cmd_axi_pkg::axi_id_t    awid_o,
  output cmd_axi_pkg::axi_len_t   awlen_o,
  output logic [1:0]              awburst_o,
  output logic                    wvalid_o,
  input  logic                    wready_i,
  output cmd_axi_pkg::data_t      wdata_o,
  output logic [3:0]              wstrb_o,
  output logic                    wlast_o,
  input  logic                    bvalid_i,
  output logic                    bready_o,
  input  cmd_axi_pkg::resp_t      bresp_i,
  input  cmd_axi_pkg::axi_id_t    bid_i,
  output logic                    arvalid_o,
  input  logic                    arready_i,
  output cmd_axi_pkg::addr_t      araddr_o,
  output cmd_axi_pkg::axi_id_t    arid_o,
  output cmd_axi_pkg::axi_len_t   arlen_o,
  output logic [1:0]              arburst_o,
  input  logic                    rvalid_i,
  output logic                    rready_o,
  input  cmd_axi_pkg::data_t      rdata_i,
  input  cmd_axi_pkg::resp_t      rresp_i,
  input  logic                    rlast_i
);
  import cmd_axi_pkg::*;

  word_beat_t pk_word;      // Packer to write FIFO
  logic       pk_stb;
  word_beat_t wf_data;
  logic       wf_empty;
  logic       wf_pop;
  word_beat_t rf_push_data; // Read engine to read FIFO
  logic       rf_push;
  word_beat_t rf_data;
  logic       rf_empty;
  logic       rf_full;
  logic       rf_pop;
  logic       wr_busy;
  logic       rd_busy;
  logic       drain_done;

  assign busy_o     = wr_busy || rd_busy;
  assign drain_done = rd_stb_o && rd_byte_o.last;

  // Write path
  byte_word_packer u_packer (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .byte_stb_i (wr_stb_i),
    .byte_i     (wr_byte_i),
    .word_stb_o (pk_stb),
    .word_o     (pk_word)
  );

  word_fifo #(.DEPTH(FIFO_DEPTH)) u_wr_fifo (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .push_i      (pk_stb),
    .push_data_i (pk_word),
    .pop_i       (wf_pop),
    .pop_data_o  (wf_data),
    .empty_o     (wf_empty),
    .full_o      ()  // A single burst never fills it
  );

  axi_write_engine u_wr_eng (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .cmd_stb_i    (cmd_stb_i),
    .cmd_i        (cmd_i),
    .fifo_data_i  (wf_data),
    .fifo_empty_i (wf_empty),
    .fifo_pop_o   (wf_pop),
    .awvalid_o    (awvalid_o),
    .awready_i    (awready_i),
    .awaddr_o     (awaddr_o),
    .awid_o       (awid_o),
    .awlen_o      (awlen_o),
    .awburst_o    (awburst_o),
    .wvalid_o     (wvalid_o),
    .wready_i     (wready_i),
    .wdata_o      (wdata_o),
    .wstrb_o      (wstrb_o),
    .wlast_o      (wlast_o),
    .bvalid_i     (bvalid_i),
    .bready_o     (bready_o),
    .bresp_i      (bresp_i),
    .bid_i        (bid_i),
    .resp_stb_o   (wr_resp_stb_o),
    .resp_o       (wr_resp_o),
    .busy_o       (wr_busy)
  );

  // Read path
  axi_read_engine u_rd_eng (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .cmd_stb_i    (cmd_stb_i),
    .cmd_i        (cmd_i),
    .fifo_full_i  (rf_full),
    .fifo_push_o  (rf_push),
    .fifo_data_o  (rf_push_data),
    .arvalid_o    (arvalid_o),
    .arready_i    (arready_i),
    .araddr_o     (araddr_o),
    .arid_o       (arid_o),
    .arlen_o      (arlen_o),
    .arburst_o    (arburst_o),
    .rvalid_i     (rvalid_i),
    .rready_o     (rready_o),
    .rdata_i      (rdata_i),
    .rresp_i      (rresp_i),
    .rlast_i      (rlast_i),
    .drain_done_i (drain_done),
    .busy_o       (rd_busy)
  );

  word_fifo #(.DEPTH(FIFO_DEPTH)) u_rd_fifo (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .push_i      (rf_push),
    .push_data_i (rf_push_data),
    .pop_i       (rf_pop),
    .pop_data_o  (rf_data),
    .empty_o     (rf_empty),
    .full_o      (rf_full)
  );

  word_byte_unpacker u_unpacker (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .fifo_data_i  (rf_data),
    .fifo_empty_i (rf_empty),
    .fifo_pop_o   (rf_pop),
    .byte_stb_o   (rd_stb_o),
    .byte_o       (rd_byte_o)
  );

endmodule

/* verif/cmd_to_axi_asserts.sv */
module cmd_to_axi_asserts (
  input logic               aclk,
  input logic               aresetn,
  input logic               cmd_stb_i,
  input logic               busy_o,
  input logic               awvalid_o,
  input logic               awready_i,
  input cmd_axi_pkg::addr_t awaddr_o,
  input logic               arvalid_o,
  input logic               arready_i,
  input cmd_axi_pkg::addr_t araddr_o,
  input logic               wvalid_o,
  input logic               wlast_o,
  input logic               rd_stb_o,
  input logic               wr_busy,
  input logic               rd_busy
);
  timeunit 1ns;
  timeprecision 1ns;

  // Host may only issue a command while the bridge is idle
  a_cmd_when_idle: assert property (@(posedge aclk) disable iff (!aresetn)
    cmd_stb_i |-> !busy_o) else $error("command strobe while busy");

  a_aw_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o))
    else $error("AW dropped or changed before ready");

  a_ar_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o))
    else $error("AR dropped or changed before ready");

  a_wlast_valid: assert property (@(posedge aclk) disable iff (!aresetn)
    wlast_o |-> wvalid_o) else $error("wlast without wvalid");

  a_rd_busy: assert property (@(posedge aclk) disable iff (!aresetn)
    rd_stb_o |-> (wr_busy || rd_busy)) else $error("read byte while both engines idle");

endmodule

bind cmd_to_axi cmd_to_axi_asserts u_asserts (.*);

/* verif/axi_mem_model.sv */
module axi_mem_model #(
  parameter int SEED = 0
) (
  input  logic                  aclk,
  input  logic                  aresetn,
  input  logic                  heavy_i,   // Longer ready and valid stalls
  input  logic                  awvalid_i,
  output logic                  awready_o,
  input  cmd_axi_pkg::addr_t    awaddr_i,
  input  cmd_axi_pkg::axi_id_t  awid_i,
  input  logic                  wvalid_i,
  output logic                  wready_o,
  input  cmd_axi_pkg::data_t    wdata_i,
  input  logic                  wlast_i,
  output logic                  bvalid_o,
  input  logic                  bready_i,
  output cmd_axi_pkg::resp_t    bresp_o,
  output cmd_axi_pkg::axi_id_t  bid_o,
  input  logic                  arvalid_i,
  output logic                  arready_o,
  input  cmd_axi_pkg::addr_t    araddr_i,
  input  cmd_axi_pkg::axi_len_t arlen_i,
  output logic                  rvalid_o,
  input  logic                  rready_i,
  output cmd_axi_pkg::data_t    rdata_o,
  output cmd_axi_pkg::resp_t    rresp_o,
  output logic                  rlast_o
);
  timeunit 1ns;
  timeprecision 1ns;
  import cmd_axi_pkg::*;

  localparam int WORDS = 1024;
  localparam int ERR_BIT = 15;  // Addresses with this bit set answer SLVERR

  data_t    mem [WORDS];
  int       seed = SEED;
  logic [1:0] wstate;           // 0 address, 1 data, 2 response
  logic [9:0] wptr;
  logic     werr;
  logic     rbusy;
  logic [9:0] rptr;
  axi_len_t rcnt;
  axi_len_t rlen;
  logic     rerr;

  // One in two cycles ready, one in four under heavy stalls
  function automatic logic ready_roll();
    return (($random(seed) & (heavy_i ? 3 : 1)) == 0);
  endfunction

  always @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      bresp_o   <= RESP_OKAY;
      bid_o     <= '0;
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
      rdata_o   <= '0;
      rresp_o   <= RESP_OKAY;
      rlast_o   <= 1'b0;
      wstate    <= 2'd0;
      wptr      <= '0;
      werr      <= 1'b0;
      rbusy     <= 1'b0;
      rptr      <= '0;
      rcnt      <= '0;
      rlen      <= '0;
      rerr      <= 1'b0;
      for (int i = 0; i < WORDS; i++) begin
        mem[i] <= '0;
      end
    end else begin
      case (wstate)
        2'd0: begin
          if (awvalid_i && awready_o) begin
            awready_o <= 1'b0;
            wptr      <= awaddr_i[11:2];
            werr      <= awaddr_i[ERR_BIT];
            bid_o     <= awid_i;
            wstate    <= 2'd1;
          end else begin
            awready_o <= ready_roll();
          end
        end
        2'd1: begin
          if (wvalid_i && wready_o) begin
            if (!werr) mem[wptr] <= wdata_i;  // Error region keeps memory intact
            wptr <= wptr + 10'd1;
            if (wlast_i) wstate <= 2'd2;
          end
          wready_o <= !(wvalid_i && wready_o && wlast_i) && ready_roll();
        end
        default: begin
          if (bvalid_o && bready_i) begin
            bvalid_o <= 1'b0;
            wstate   <= 2'd0;
          end else if (!bvalid_o) begin
            bvalid_o <= ready_roll();
            bresp_o  <= werr ? RESP_SLVERR : RESP_OKAY;
          end
        end
      endcase

      // Read side, one beat presented at a time
      if (!rbusy) begin
        if (arvalid_i && arready_o) begin
          arready_o <= 1'b0;
          rptr      <= araddr_i[11:2];
          rerr      <= araddr_i[ERR_BIT];
          rlen      <= arlen_i;
          rcnt      <= '0;
          rbusy     <= 1'b1;
        end else begin
          arready_o <= ready_roll();
        end
      end else if (rvalid_o) begin
        if (rready_i) begin
          rvalid_o <= 1'b0;
          rptr     <= rptr + 10'd1;
          rcnt     <= rcnt + 8'd1;
          if (rlast_o) rbusy <= 1'b0;
        end
      end else if (ready_roll()) begin
        rvalid_o <= 1'b1;
        rdata_o  <= rerr ? '0 : mem[rptr];
        rresp_o  <= rerr ? RESP_SLVERR : RESP_OKAY;
        rlast_o  <= (rcnt == rlen);
      end
    end
  end

endmodule

/* verif/tb_cmd_to_axi.sv */
module tb_cmd_to_axi;
  timeunit 1ns;
  timeprecision 1ns;
  import cmd_axi_pkg::*;

  localparam int NUM_TESTS = 40;
  localparam int ERR_BIT   = 15;
  localparam int TIMEOUT   = NUM_TESTS * 16 * 4 * 8;  // Tests x beats x bytes x stall factor

  int         seed = 32'hf6a9_177c;
  int         cycles;
  logic       aclk;
  logic       aresetn;
  logic       heavy_stall;
  logic       cmd_stb;
  host_cmd_t  cmd;
  logic       wr_stb;
  host_byte_t wr_byte;
  logic       rd_stb;
  rd_byte_t   rd_byte;
  logic       wr_resp_stb;
  wr_resp_t   wr_resp;
  logic       busy;
  logic       awvalid, awready, wvalid, wready, wlast, bvalid, bready;
  logic       arvalid, arready, rvalid, rready, rlast;
  addr_t      awaddr, araddr;
  axi_id_t    awid, bid, arid;
  axi_len_t   awlen, arlen;
  logic [1:0] awburst, arburst;
  data_t      wdata, rdata;
  logic [3:0] wstrb;
  resp_t      bresp, rresp;

  data_t      shadow [1024];  // Word image of the memory outside the error region
  rd_byte_t   exp_rd [$];
  wr_resp_t   exp_resp [$];

  cmd_to_axi DUT (
    .aclk(aclk), .aresetn(aresetn),
    .cmd_stb_i(cmd_stb), .cmd_i(cmd), .wr_stb_i(wr_stb), .wr_byte_i(wr_byte),
    .rd_stb_o(rd_stb), .rd_byte_o(rd_byte), .wr_resp_stb_o(wr_resp_stb),
    .wr_resp_o(wr_resp), .busy_o(busy),
    .awvalid_o(awvalid), .awready_i(awready), .awaddr_o(awaddr), .awid_o(awid),
    .awlen_o(awlen), .awburst_o(awburst), .wvalid_o(wvalid), .wready_i(wready),
    .wdata_o(wdata), .wstrb_o(wstrb), .wlast_o(wlast), .bvalid_i(bvalid),
    .bready_o(bready), .bresp_i(bresp), .bid_i(bid),
    .arvalid_o(arvalid), .arready_i(arready), .araddr_o(araddr), .arid_o(arid),
    .arlen_o(arlen), .arburst_o(arburst), .rvalid_i(rvalid), .rready_o(rready),
    .rdata_i(rdata), .rresp_i(rresp), .rlast_i(rlast)
  );

  axi_mem_model #(.SEED(32'hf6a9_177c)) u_mem (
    .aclk(aclk), .aresetn(aresetn), .heavy_i(heavy_stall),
    .awvalid_i(awvalid), .awready_o(awready), .awaddr_i(awaddr), .awid_i(awid),
    .wvalid_i(wvalid), .wready_o(wready), .wdata_i(wdata), .wlast_i(wlast),
    .bvalid_o(bvalid), .bready_i(bready), .bresp_o(bresp), .bid_o(bid),
    .arvalid_i(arvalid), .arready_o(arready), .araddr_i(araddr), .arlen_i(arlen),
    .rvalid_o(rvalid), .rready_i(rready), .rdata_o(rdata), .rresp_o(rresp),
    .rlast_o(rlast)
  );

  initial begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  task automatic report_failure();
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
      report_failure();
    end
  endtask

  // Expected byte k of a read burst, little-endian within each word
  function automatic rd_byte_t expect_rd_byte(addr_t addr, beats_t beats, int k);
    rd_byte_t   b;
    logic [9:0] idx;
    data_t      w;
    idx    = addr[11:2] + 10'(k / 4);
    w      = shadow[idx];
    b.err  = addr[ERR_BIT];
    b.data = b.err ? 8'h00 : w[8 * (k % 4) +: 8];
    b.last = (k == 4 * int'(beats) - 1);
    return b;
  endfunction

  function automatic wr_resp_t expect_wr_resp(axi_id_t id, addr_t addr);
    wr_resp_t r;
    r.id   = id;
    r.okay = !addr[ERR_BIT];
    return r;
  endfunction

  function automatic addr_t random_addr();
    addr_t a;
    a = addr_t'({$random(seed)} % 1008) << 2;  // Room for a full burst
    if (($random(seed) & 7) == 0) a[ERR_BIT] = 1'b1;
    return a;
  endfunction

  task automatic issue_cmd(logic dir, axi_id_t id, beats_t beats, addr_t addr);
    @(negedge aclk);
    cmd_stb   = 1'b1;
    cmd.dir   = dir;
    cmd.id    = id;
    cmd.beats = beats;
    cmd.addr  = addr;
  endtask

  task automatic wait_idle();
    while (busy) @(negedge aclk);
  endtask

  task automatic run_write(axi_id_t id, addr_t addr, beats_t beats, data_t first);
    data_t w;
    exp_resp.push_back(expect_wr_resp(id, addr));
    issue_cmd(1'b0, id, beats, addr);
    for (int i = 0; i < int'(beats); i++) begin
      w = (i == 0 && first != '0) ? first : $random(seed);
      if (!addr[ERR_BIT]) shadow[addr[11:2] + 10'(i)] = w;
      for (int j = 0; j < 4; j++) begin
        @(negedge aclk);
        if (i == 0 && j == 0) check_value("busy after command", 32'(busy), 32'd1);
        cmd_stb      = 1'b0;
        wr_stb       = 1'b1;
        wr_byte.data = w[8 * j +: 8];
        wr_byte.last = (i == int'(beats) - 1) && (j == 3);
      end
    end
    @(negedge aclk);
    wr_stb = 1'b0;
    wait_idle();
  endtask

  task automatic run_read(axi_id_t id, addr_t addr, beats_t beats);
    for (int k = 0; k < 4 * int'(beats); k++) begin
      exp_rd.push_back(expect_rd_byte(addr, beats, k));
    end
    issue_cmd(1'b1, id, beats, addr);
    @(negedge aclk);
    cmd_stb = 1'b0;
    check_value("busy after command", 32'(busy), 32'd1);
    wait_idle();
  endtask

  // Compare host-side events against the queued expectations
  always @(negedge aclk) begin : compare_events
    rd_byte_t e_rd;
    wr_resp_t e_resp;
    if (aresetn && rd_stb) begin
      if (exp_rd.size() == 0) begin
        $display("read byte arrived while none was expected");
        report_failure();
      end else begin
        e_rd = exp_rd.pop_front();
        check_value("read data", 32'(rd_byte.data), 32'(e_rd.data));
        check_value("read last", 32'(rd_byte.last), 32'(e_rd.last));
        check_value("read error", 32'(rd_byte.err), 32'(e_rd.err));
        check_value("busy during read", 32'(busy), 32'd1);
      end
    end
    if (aresetn && wr_resp_stb) begin
      if (exp_resp.size() == 0) begin
        $display("write response arrived while none was expected");
        report_failure();
      end else begin
        e_resp = exp_resp.pop_front();
        check_value("response id", 32'(wr_resp.id), 32'(e_resp.id));
        check_value("response okay", 32'(wr_resp.okay), 32'(e_resp.okay));
        check_value("busy at response", 32'(busy), 32'd0);
      end
    end
    // cmd keeps the active command until the next one is issued
    if (aresetn && awvalid) begin
      check_value("awaddr", 32'(awaddr), 32'(cmd.addr));
      check_value("awid", 32'(awid), 32'(cmd.id));
      check_value("awlen", 32'(awlen), 32'(cmd.beats) - 32'd1);
      check_value("awburst", 32'(awburst), 32'd1);  // INCR
    end
    if (aresetn && wvalid) begin
      check_value("wstrb", 32'(wstrb), 32'hf);
    end
    if (aresetn && arvalid) begin
      check_value("araddr", 32'(araddr), 32'(cmd.addr));
      check_value("arid", 32'(arid), 32'(cmd.id));
      check_value("arlen", 32'(arlen), 32'(cmd.beats) - 32'd1);
      check_value("arburst", 32'(arburst), 32'd1);
    end
  end

  always @(posedge aclk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("timeout after %0d cycles, the bridge stopped responding", TIMEOUT);
      report_failure();
    end
  end

  initial begin
    logic   dir;
    axi_id_t id;
    beats_t beats;
    cycles      = 0;
    aresetn     = 1'b0;
    heavy_stall = 1'b0;
    cmd_stb     = 1'b0;
    cmd         = '0;
    wr_stb      = 1'b0;
    wr_byte     = '0;
    for (int i = 0; i < 1024; i++) begin
      shadow[i] = '0;
    end
    repeat (10) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;

    // Single word round trip
    run_write(4'd3, 32'h40, 5'd1, 32'h4433_2211);
    run_read(4'd3, 32'h40, 5'd1);

    // Full burst under heavy stalls
    heavy_stall = 1'b1;
    run_write(4'd5, 32'h100, 5'd16, '0);
    run_read(4'd5, 32'h100, 5'd16);
    heavy_stall = 1'b0;

    // Separate addresses with interleaved read-back
    run_write(4'd1, 32'h200, 5'd4, '0);
    run_write(4'd2, 32'h300, 5'd2, '0);
    run_read(4'd1, 32'h200, 5'd4);
    run_write(4'd4, 32'h208, 5'd1, '0);
    run_read(4'd2, 32'h300, 5'd2);
    run_read(4'd6, 32'h200, 5'd4);

    // Error region leaves the aliased words untouched
    run_write(4'd7, 32'h40, 5'd3, '0);
    run_write(4'd8, 32'h8040, 5'd3, '0);
    run_read(4'd9, 32'h8040, 5'd3);
    run_read(4'd10, 32'h40, 5'd3);

    for (int t = 0; t < NUM_TESTS; t++) begin
      dir         = ($random(seed) & 1) != 0;
      id          = axi_id_t'($random(seed));
      beats       = beats_t'(1 + {$random(seed)} % 16);
      heavy_stall = ($random(seed) & 3) == 0;
      if (dir) run_read(id, random_addr(), beats);
      else run_write(id, random_addr(), beats, '0);
    end

    @(negedge aclk);  // One more edge so the compare process has seen the last response
    if (exp_rd.size() == 0 && exp_resp.size() == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("expected read bytes or write responses never arrived");
      report_failure();
    end
  end

endmodule

/* vlog.f */
source/cmd_axi_pkg.sv
source/byte_word_packer.sv
source/word_fifo.sv
source/axi_write_engine.sv
source/axi_read_engine.sv
source/word_byte_unpacker.sv
source/cmd_to_axi.sv
verif/cmd_to_axi_asserts.sv
verif/axi_mem_model.sv
verif/tb_cmd_to_axi.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module tb_cmd_to_axi -o sim_tb

output=$(./obj_dir/sim_tb || true)
echo "$output"

if grep -qx "Test OK" <<< "$output"; then
  exit 0
else
  exit 1
fi
